// ==== logic/uart_rx_params.svh ====
// ----------------------------------------
// Shared sizing macros of the UART receiver
// Include before any module or package that
// needs the oversampling or FIFO geometry
// ----------------------------------------

`ifndef UART_RX_PARAMS_SVH
`define UART_RX_PARAMS_SVH

// Phase ticks per serial bit
`define UART_RX_OVERSAMPLE 16

// Phase at which the bit value is taken
`define UART_RX_CENTER 8

// Flops in the rxd input synchronizer
`define UART_RX_SYNC_STAGES 2

// Receive FIFO entries, power of two
`define UART_RX_FIFO_DEPTH 16

`endif

// ==== logic/uart_rx_cfg_pkg.sv ====
// ----------------------------------------
// Line configuration types of the receiver
// Used on the config ports of top and framer
// ----------------------------------------

package uart_rx_cfg_pkg;

  // Word length code, 0..3 maps to 5..8 data bits
  typedef logic [1:0] word_len_t;

  // Parity check mode, only looked at when parity is enabled
  typedef enum logic [1:0] {
    PAR_ODD    = 2'b00,  // Data XOR parity must be 1
    PAR_EVEN   = 2'b01,  // Data XOR parity must be 0
    PAR_FORCE1 = 2'b10,  // Parity bit stuck at 1
    PAR_FORCE0 = 2'b11   // Parity bit stuck at 0
  } parity_mode_e;

  // FIFO fill level that raises the trigger
  typedef enum logic [1:0] {
    TRIG_1  = 2'b00,
    TRIG_4  = 2'b01,
    TRIG_8  = 2'b10,
    TRIG_14 = 2'b11
  } trig_level_e;

endpackage

// ==== logic/uart_rx_data_pkg.sv ====
// ----------------------------------------
// Types for received data and receiver state
// Shared by sampler, framer, FIFO and top
// ----------------------------------------

`include "uart_rx_params.svh"

package uart_rx_data_pkg;

  // Received character, upper bits zero for short words
  typedef logic [7:0] rx_char_t;

  // FIFO entry: {parity err, framing err, break, char}
  typedef logic [10:0] rx_entry_t;

  // Oversample phase, one spare bit above the count range
  typedef logic [$clog2(`UART_RX_OVERSAMPLE):0] phase_t;

  // FIFO fill count, 0 up to and including the depth
  typedef logic [$clog2(`UART_RX_FIFO_DEPTH):0] fifo_usage_t;

  // Framer FSM
  typedef enum logic [2:0] {
    RX_IDLE,    // Hunting for a falling edge
    RX_START,   // Verify start bit at its center
    RX_DATA,    // Shift in data bits, LSB first
    RX_PAR,     // Parity bit
    RX_STOP,    // Stop bit, frame ends here
    RX_RESYNC   // After framing error
  } rx_state_e;

endpackage

// ==== logic/uart_rx_sampler.sv ====
// ----------------------------------------
// Front end of the receiver: synchronizer,
// oversample phase counter, bit-center pulse
// and 3-sample majority filter
// ----------------------------------------

`timescale 1ns/1ps

`include "uart_rx_params.svh"

module uart_rx_sampler (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic oversample_tick_i,  // One clk per 1/16 bit
  input  logic rxd_i,              // Asynchronous serial line
  input  logic hunt_i,             // Framer idle, hold phase at 0
  output logic rxd_sync_o,
  output logic bit_center_o,
  output logic bit_o
);

  import uart_rx_data_pkg::*;

  localparam phase_t PH_LAST   = phase_t'(`UART_RX_OVERSAMPLE - 1);
  localparam phase_t PH_CENTER = phase_t'(`UART_RX_CENTER);
  localparam phase_t PH_CLR    = phase_t'(`UART_RX_CENTER - 4);  // Filter init
  localparam phase_t PH_FIRST  = phase_t'(`UART_RX_CENTER - 3);  // First sample
  localparam phase_t PH_FINAL  = phase_t'(`UART_RX_CENTER - 1);  // Last sample

  logic [`UART_RX_SYNC_STAGES-1:0] sync_q;
  phase_t     phase_q;
  logic       center_q;      // Phase was at center last clk
  logic [1:0] high_cnt_q;    // High samples seen so far
  logic [1:0] high_cnt_sum;
  logic       bit_q;

  // ----------------------------------------
  // Input synchronizer
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '1;  // Idle line is high
    end else begin
      sync_q <= {sync_q[`UART_RX_SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign rxd_sync_o = sync_q[`UART_RX_SYNC_STAGES-1];

  // ----------------------------------------
  // Phase counter and center pulse
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q  <= '0;
      center_q <= 1'b0;
    end else begin
      center_q <= (phase_q == PH_CENTER);
      if (hunt_i) begin
        phase_q <= '0;  // Restart from edge of start bit
      end else if (oversample_tick_i) begin
        phase_q <= (phase_q == PH_LAST) ? '0 : phase_q + phase_t'(1);
      end
    end
  end

  // Phase stays at center for a whole tick period, pulse only on entry
  assign bit_center_o = (phase_q == PH_CENTER) & ~center_q;

  // ----------------------------------------
  // Majority filter
  // ----------------------------------------
  assign high_cnt_sum = high_cnt_q + {1'b0, rxd_sync_o};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      high_cnt_q <= '0;
      bit_q      <= 1'b1;
    end else if (phase_q == PH_CLR) begin
      high_cnt_q <= '0;
    end else if (oversample_tick_i && (phase_q >= PH_FIRST) && (phase_q <= PH_FINAL)) begin
      high_cnt_q <= high_cnt_sum;
      if (phase_q == PH_FINAL) begin
        bit_q <= high_cnt_sum[1];  // 2 or 3 of 3 high
      end
    end
  end

  assign bit_o = bit_q;  // Settled before the center pulse

endmodule

// ==== logic/uart_rx_framer.sv ====
// ----------------------------------------
// Framing FSM of the receiver. Takes filtered
// bits at each center, checks parity, stop and
// break, emits one entry per frame
// ----------------------------------------

`timescale 1ns/1ps

module uart_rx_framer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         rxd_sync_i,
  input  logic                         bit_center_i,
  input  logic                         bit_i,
  input  uart_rx_cfg_pkg::word_len_t    word_len_i,
  input  logic                         par_en_i,
  input  uart_rx_cfg_pkg::parity_mode_e par_mode_i,
  output logic                         hunt_o,
  output logic                         char_valid_o,
  output uart_rx_data_pkg::rx_entry_t   char_o
);

  import uart_rx_cfg_pkg::*;
  import uart_rx_data_pkg::*;

  rx_state_e  state_q, state_d;
  logic [2:0] bit_cnt_q, bit_cnt_d;  // Index of next data bit
  logic [2:0] last_idx;              // Index of final data bit
  rx_char_t   shift_q, shift_d;
  logic       zero_q, zero_d;        // All bits so far were 0
  logic       par_err_q, par_err_d;
  logic       data_par;
  logic       par_bad;
  logic       brk;

  assign last_idx = 3'(word_len_i) + 3'd4;  // 5 bits -> index 4
  assign data_par = ^shift_q;                // Unused bits are 0

  // ----------------------------------------
  // Parity check of the sampled parity bit
  // ----------------------------------------
  always_comb begin
    case (par_mode_i)
      PAR_ODD:    par_bad = ~(data_par ^ bit_i);
      PAR_EVEN:   par_bad = data_par ^ bit_i;
      PAR_FORCE1: par_bad = ~bit_i;
      PAR_FORCE0: par_bad = bit_i;
      default:    par_bad = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    bit_cnt_d = bit_cnt_q;
    shift_d   = shift_q;
    zero_d    = zero_q;
    par_err_d = par_err_q;

    case (state_q)
      RX_IDLE: begin
        if (!rxd_sync_i) begin
          state_d = RX_START;  // Falling edge, phase starts counting
        end
      end

      RX_START: begin
        if (bit_center_i) begin
          if (bit_i) begin
            state_d = RX_IDLE;  // Glitch, not a start bit
          end else begin
            shift_d   = '0;
            bit_cnt_d = '0;
            zero_d    = 1'b1;
            par_err_d = 1'b0;
            state_d   = RX_DATA;
          end
        end
      end

      RX_DATA: begin
        if (bit_center_i) begin
          shift_d[bit_cnt_q] = bit_i;  // LSB first
          zero_d             = zero_q & ~bit_i;
          bit_cnt_d          = bit_cnt_q + 3'd1;
          if (bit_cnt_q == last_idx) begin
            state_d = par_en_i ? RX_PAR : RX_STOP;
          end
        end
      end

      RX_PAR: begin
        if (bit_center_i) begin
          par_err_d = par_bad;
          zero_d    = zero_q & ~bit_i;
          state_d   = RX_STOP;
        end
      end

      RX_STOP: begin
        if (bit_center_i) begin
          state_d = bit_i ? RX_IDLE : RX_RESYNC;  // Low stop = framing error
        end
      end

      RX_RESYNC: begin
        // Line still low may already be the next start bit
        state_d = rxd_sync_i ? RX_IDLE : RX_START;
      end

      default: state_d = RX_IDLE;
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      bit_cnt_q <= bit_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q   <= shift_d;
    zero_q    <= zero_d;
    par_err_q <= par_err_d;
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign hunt_o       = (state_q == RX_IDLE);
  assign char_valid_o = (state_q == RX_STOP) & bit_center_i;  // Stop-bit center
  assign brk          = zero_q & ~bit_i;                      // Stop bit low too
  assign char_o       = {par_err_q, ~bit_i, brk, shift_q};

endmodule

// ==== logic/uart_rx_fifo.sv ====
// ----------------------------------------
// Receive FIFO for framed characters with
// fill count, trigger level and overrun.
// Head is visible while ready_o is high
// ----------------------------------------

`timescale 1ns/1ps

`include "uart_rx_params.svh"

module uart_rx_fifo (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        push_i,
  input  uart_rx_data_pkg::rx_entry_t  data_i,
  input  logic                        pop_i,
  input  logic                        clear_i,  // Flush, wins over push
  input  uart_rx_cfg_pkg::trig_level_e trig_level_i,
  output uart_rx_data_pkg::rx_entry_t  data_o,
  output logic                        ready_o,
  output logic                        trigger_o,
  output logic                        overrun_o
);

  import uart_rx_cfg_pkg::*;
  import uart_rx_data_pkg::*;

  localparam int          PTR_W    = $clog2(`UART_RX_FIFO_DEPTH);
  localparam fifo_usage_t FULL_CNT = fifo_usage_t'(`UART_RX_FIFO_DEPTH);

  rx_entry_t   mem_q [`UART_RX_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  fifo_usage_t usage_q;
  fifo_usage_t trig_cnt;
  logic        full;
  logic        push_ok;
  logic        pop_ok;

  assign full    = (usage_q == FULL_CNT);
  assign ready_o = (usage_q != '0);
  assign push_ok = push_i & ~full;
  assign pop_ok  = pop_i & ready_o;

  // Character arrives with no back-pressure, so it is lost here
  assign overrun_o = push_i & full;

  // ----------------------------------------
  // Pointers and fill count
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   usage_q <= usage_q + fifo_usage_t'(1);
        2'b01:   usage_q <= usage_q - fifo_usage_t'(1);
        default: usage_q <= usage_q;  // None or both
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o = mem_q[rd_ptr_q];

  // ----------------------------------------
  // Trigger level
  // ----------------------------------------
  always_comb begin
    case (trig_level_i)
      TRIG_1:  trig_cnt = fifo_usage_t'(1);
      TRIG_4:  trig_cnt = fifo_usage_t'(4);
      TRIG_8:  trig_cnt = fifo_usage_t'(8);
      TRIG_14: trig_cnt = fifo_usage_t'(14);
      default: trig_cnt = fifo_usage_t'(1);
    endcase
  end

  assign trigger_o = (usage_q >= trig_cnt);

endmodule

// ==== logic/uart_rx_top.sv ====
// ----------------------------------------
// UART receiver top: sampler, framer and
// receive FIFO. Host pops the FIFO head
// ----------------------------------------

`timescale 1ns/1ps

module uart_rx_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         oversample_tick_i,
  input  logic                         rxd_i,
  input  uart_rx_cfg_pkg::word_len_t    word_len_i,
  input  logic                         par_en_i,
  input  uart_rx_cfg_pkg::parity_mode_e par_mode_i,
  input  uart_rx_cfg_pkg::trig_level_e  trig_level_i,
  input  logic                         fifo_clear_i,
  input  logic                         pop_i,
  output uart_rx_data_pkg::rx_entry_t   rx_entry_o,
  output logic                         rx_ready_o,
  output logic                         trigger_o,
  output logic                         overrun_o
);

  import uart_rx_data_pkg::*;

  logic      rxd_sync;
  logic      bit_center;
  logic      bit_val;     // Majority-filtered bit
  logic      hunt;
  rx_entry_t char_entry;
  logic      char_valid;  // One clk per received frame

  uart_rx_sampler u_sampler (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .oversample_tick_i(oversample_tick_i),
    .rxd_i            (rxd_i),
    .hunt_i           (hunt),
    .rxd_sync_o       (rxd_sync),
    .bit_center_o     (bit_center),
    .bit_o            (bit_val)
  );

  uart_rx_framer u_framer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rxd_sync_i  (rxd_sync),
    .bit_center_i(bit_center),
    .bit_i       (bit_val),
    .word_len_i  (word_len_i),
    .par_en_i    (par_en_i),
    .par_mode_i  (par_mode_i),
    .hunt_o      (hunt),
    .char_valid_o(char_valid),
    .char_o      (char_entry)
  );

  // Push straight from the framer, overrun when full
  uart_rx_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (char_valid),
    .data_i      (char_entry),
    .pop_i       (pop_i),
    .clear_i     (fifo_clear_i),
    .trig_level_i(trig_level_i),
    .data_o      (rx_entry_o),
    .ready_o     (rx_ready_o),
    .trigger_o   (trigger_o),
    .overrun_o   (overrun_o)
  );

endmodule

// ==== tests/uart_rx_assertions.sv ====
// ----------------------------------------
// Concurrent checks on the receiver top,
// bound into every uart_rx_top instance
// ----------------------------------------

`timescale 1ns/1ps

`include "uart_rx_params.svh"

module uart_rx_assertions (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        oversample_tick_i,
  input logic                        bit_center_i,
  input logic                        char_valid_i,
  input logic                        pop_i,
  input logic                        clear_i,
  input logic                        overrun_i,
  input logic                        trigger_i,
  input logic                        rx_ready_i,
  input uart_rx_data_pkg::rx_state_e state_i
);

  import uart_rx_data_pkg::*;

  localparam int DEPTH    = `UART_RX_FIFO_DEPTH;
  localparam int HALF_BIT = `UART_RX_OVERSAMPLE / 2;

  int fill_q;   // Entries held, from push, pop and flush
  int ticks_q;  // Ticks since the last center pulse

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_q <= 0;
    end else if (clear_i) begin
      fill_q <= 0;
    end else begin
      fill_q <= fill_q + ((char_valid_i && fill_q < DEPTH) ? 1 : 0)
                       - ((pop_i && fill_q > 0) ? 1 : 0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ticks_q <= HALF_BIT;  // First pulse is free
    end else if (bit_center_i) begin
      ticks_q <= 0;
    end else if (oversample_tick_i && ticks_q < DEPTH) begin
      ticks_q <= ticks_q + 1;  // Saturates, only the minimum matters
    end
  end

  // One clk pulse and at least half a bit to the next
  a_center_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bit_center_i |-> (ticks_q >= HALF_BIT))
    else $error("bit-center pulse repeated within half a bit time");

  // A push that fits never flags overrun
  a_no_false_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (char_valid_i && fill_q < DEPTH) |-> !overrun_i)
    else $error("overrun raised on a push into a FIFO with free space");

  a_trigger_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trigger_i |-> rx_ready_i)
    else $error("trigger high while the FIFO is empty");

  // Framer starts out hunting
  a_idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (state_i == RX_IDLE))
    else $error("framer not idle in the first cycle after reset");

endmodule

bind uart_rx_top uart_rx_assertions u_assertions (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .oversample_tick_i(oversample_tick_i),
  .bit_center_i     (bit_center),
  .char_valid_i     (char_valid),
  .pop_i            (pop_i),
  .clear_i          (fifo_clear_i),
  .overrun_i        (overrun_o),
  .trigger_i        (trigger_o),
  .rx_ready_i       (rx_ready_o),
  .state_i          (u_framer.state_q)
);

// ==== tests/uart_rx_tb.sv ====
// ----------------------------------------
// Testbench of the UART receiver top. Sends
// serial frames from a table and LFSR data,
// checks FIFO entries, trigger and overrun
// ----------------------------------------

`timescale 1ns/1ps

`include "uart_rx_params.svh"

module uart_rx_tb;

  import uart_rx_cfg_pkg::*;
  import uart_rx_data_pkg::*;

  localparam int TICK_DIV = 4;                               // Clks per oversample tick
  localparam int BIT_CLKS = `UART_RX_OVERSAMPLE * TICK_DIV;  // 64 clks per bit
  localparam int WAIT_MAX = 20 * BIT_CLKS;
  localparam int N_ROWS   = 18;

  logic         clk;
  logic         rst_n;
  logic         tick;
  logic         rxd;
  word_len_t    word_len;
  logic         par_en;
  parity_mode_e par_mode;
  trig_level_e  trig_level;
  logic         fifo_clear;
  logic         pop;
  rx_entry_t    rx_entry;
  logic         rx_ready;
  logic         trigger;
  logic         overrun;

  logic [1:0]  tick_div;
  logic [31:0] lfsr;
  logic [17:0] stim_tbl [N_ROWS];  // {wlen, pen, mode, data, flip, stop, flags}
  rx_entry_t   exp_q [$];          // Entries expected in the FIFO, oldest first
  int          check_cnt;
  int          mismatch_cnt;
  int          timeout_cnt;
  int          ovr_cnt;

  uart_rx_top UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .oversample_tick_i(tick),
    .rxd_i            (rxd),
    .word_len_i       (word_len),
    .par_en_i         (par_en),
    .par_mode_i       (par_mode),
    .trig_level_i     (trig_level),
    .fifo_clear_i     (fifo_clear),
    .pop_i            (pop),
    .rx_entry_o       (rx_entry),
    .rx_ready_o       (rx_ready),
    .trigger_o        (trigger),
    .overrun_o        (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // One tick every 4th clk
  always @(negedge clk) begin
    tick_div <= tick_div + 2'd1;
    tick     <= (tick_div == 2'd3);
  end

  always @(negedge clk) begin
    if (rst_n && overrun) ovr_cnt <= ovr_cnt + 1;  // Overrun pulse counter
  end

  // ----------------------------------------
  // Reference rules and random source
  // ----------------------------------------
  function automatic logic [7:0] data_mask(input logic [1:0] wlen);
    return 8'hFF >> (2'd3 - wlen);  // Code 0 keeps 5 bits
  endfunction

  function automatic logic parity_bit(input logic [7:0] d, input logic [1:0] mode);
    case (mode)
      PAR_ODD:    return ~(^d);  // Data XOR parity gives 1
      PAR_EVEN:   return ^d;
      PAR_FORCE1: return 1'b1;
      default:    return 1'b0;
    endcase
  endfunction

  function automatic rx_entry_t expect_entry(input logic [1:0] wlen, input logic pen,
                                             input logic [1:0] mode, input logic [7:0] data,
                                             input logic flip, input logic stop);
    logic [7:0] d;
    logic       pbit;
    logic       brk;
    d    = data & data_mask(wlen);
    pbit = parity_bit(d, mode) ^ flip;
    brk  = (d == 8'h00) & ~(pen & pbit) & ~stop;  // Every bit low, stop too
    return {pen & flip, ~stop, brk, d};
  endfunction

  function automatic int trig_count(input int lv);
    case (lv)
      0:       return 1;
      1:       return 4;
      2:       return 8;
      default: return 14;
    endcase
  endfunction

  // Galois LFSR, one step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic load_table;
    stim_tbl[0]  = {2'd0, 1'b0, PAR_ODD,    8'hF5, 1'b0, 1'b1, 3'b000};  // 5 bits
    stim_tbl[1]  = {2'd1, 1'b0, PAR_ODD,    8'hEA, 1'b0, 1'b1, 3'b000};  // 6 bits
    stim_tbl[2]  = {2'd2, 1'b0, PAR_ODD,    8'hB3, 1'b0, 1'b1, 3'b000};  // 7 bits
    stim_tbl[3]  = {2'd3, 1'b0, PAR_ODD,    8'hA5, 1'b0, 1'b1, 3'b000};  // 8 bits
    stim_tbl[4]  = {2'd3, 1'b1, PAR_ODD,    8'h5C, 1'b0, 1'b1, 3'b000};
    stim_tbl[5]  = {2'd3, 1'b1, PAR_ODD,    8'h5C, 1'b1, 1'b1, 3'b100};
    stim_tbl[6]  = {2'd3, 1'b1, PAR_EVEN,   8'h5C, 1'b0, 1'b1, 3'b000};
    stim_tbl[7]  = {2'd3, 1'b1, PAR_EVEN,   8'h5C, 1'b1, 1'b1, 3'b100};
    stim_tbl[8]  = {2'd3, 1'b1, PAR_FORCE1, 8'h5C, 1'b0, 1'b1, 3'b000};
    stim_tbl[9]  = {2'd3, 1'b1, PAR_FORCE1, 8'h5C, 1'b1, 1'b1, 3'b100};
    stim_tbl[10] = {2'd3, 1'b1, PAR_FORCE0, 8'h5C, 1'b0, 1'b1, 3'b000};
    stim_tbl[11] = {2'd3, 1'b1, PAR_FORCE0, 8'h5C, 1'b1, 1'b1, 3'b100};
    stim_tbl[12] = {2'd3, 1'b0, PAR_ODD,    8'h7E, 1'b0, 1'b0, 3'b010};  // Framing
    stim_tbl[13] = {2'd3, 1'b0, PAR_ODD,    8'h00, 1'b0, 1'b0, 3'b011};  // Break
    stim_tbl[14] = {2'd3, 1'b0, PAR_ODD,    8'h3C, 1'b0, 1'b1, 3'b000};  // Recovery
    stim_tbl[15] = {2'd3, 1'b1, PAR_EVEN,   8'h00, 1'b0, 1'b0, 3'b011};
    stim_tbl[16] = {2'd3, 1'b1, PAR_FORCE1, 8'h00, 1'b0, 1'b0, 3'b010};  // Parity bit high
    stim_tbl[17] = {2'd2, 1'b1, PAR_ODD,    8'h4A, 1'b1, 1'b1, 3'b100};
  endtask

  // ----------------------------------------
  // Line driver
  // ----------------------------------------
  task automatic drive_bit(input logic b);
    rxd = b;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  task automatic send_frame(input logic [1:0] wlen, input logic pen, input logic [1:0] mode,
                            input logic [7:0] data, input logic flip, input logic stop);
    logic [7:0] d;
    int         i;
    d        = data & data_mask(wlen);
    word_len = wlen;
    par_en   = pen;
    par_mode = parity_mode_e'(mode);
    drive_bit(1'b0);  // Start bit
    for (i = 0; i < int'(wlen) + 5; i++) drive_bit(d[i]);  // LSB first
    if (pen) drive_bit(parity_bit(d, mode) ^ flip);
    drive_bit(stop);
    rxd = 1'b1;
  endtask

  // Gap covers the start check that follows a bad stop bit
  task automatic idle_gap;
    logic [31:0] r;
    take_bits(6, r);
    rxd = 1'b1;
    repeat (80 + int'(r)) @(negedge clk);
  endtask

  task automatic send_random(input logic keep);
    logic [31:0] w;
    logic [31:0] d;
    take_bits(2, w);
    take_bits(8, d);
    send_frame(w[1:0], 1'b0, PAR_ODD, d[7:0], 1'b0, 1'b1);
    if (keep) exp_q.push_back(expect_entry(w[1:0], 1'b0, PAR_ODD, d[7:0], 1'b0, 1'b1));
    idle_gap();
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    check_cnt++;
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %0d %s, expected %0d", $time, got, what, exp);
    end
  endtask

  task automatic wait_ready(output logic ok);
    int t;
    t = 0;
    while (!rx_ready && t < WAIT_MAX) begin
      @(negedge clk);
      t++;
    end
    ok = rx_ready;
    assert (ok) else begin
      timeout_cnt++;
      $display("ERROR at %0t: no character reached the FIFO within 20 bit times", $time);
    end
  endtask

  task automatic pop_check(input rx_entry_t exp);
    check_bit(rx_ready, 1'b1, "rx_ready_o before pop");
    check_cnt++;
    assert (rx_entry === exp) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: entry %h, expected %h", $time, rx_entry, exp);
    end
    pop = 1'b1;
    @(negedge clk);
    pop = 1'b0;
  endtask

  // Sweep all levels at the current fill count n
  task automatic check_trigger(input int n);
    int lv;
    for (lv = 0; lv < 4; lv++) begin
      trig_level = trig_level_e'(lv);
      @(negedge clk);
      check_bit(trigger, n >= trig_count(lv), "trigger_o");
    end
    trig_level = TRIG_1;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_n        = 1'b0;
    tick         = 1'b0;
    tick_div     = 2'd0;
    rxd          = 1'b1;
    word_len     = 2'd3;
    par_en       = 1'b0;
    par_mode     = PAR_ODD;
    trig_level   = TRIG_1;
    fifo_clear   = 1'b0;
    pop          = 1'b0;
    lfsr         = 32'h82a8;
    check_cnt    = 0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    ovr_cnt      = 0;
    load_table();

    begin : test_body
      logic [17:0] r;
      int          row;
      int          n;
      logic        ok;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (2 * BIT_CLKS) @(negedge clk);

      // Word lengths, parity modes, framing and break
      for (row = 0; row < N_ROWS; row++) begin
        r = stim_tbl[row];
        send_frame(r[17:16], r[15], r[14:13], r[12:5], r[4], r[3]);
        wait_ready(ok);
        if (!ok) disable test_body;
        pop_check({r[2:0], r[12:5] & data_mask(r[17:16])});
        check_bit(rx_ready, 1'b0, "rx_ready_o after single pop");
        idle_gap();
      end

      // Trigger levels on fill and drain
      check_trigger(0);
      for (n = 1; n <= 14; n++) begin
        send_random(1'b1);
        check_trigger(n);
      end
      for (n = 14; n >= 1; n--) begin
        pop_check(exp_q.pop_front());
        check_trigger(n - 1);
      end
      check_count(ovr_cnt, 0, "overrun pulses before fill");

      // Overrun on the 17th frame
      for (n = 0; n < 17; n++) send_random(n < 16);
      check_count(ovr_cnt, 1, "overrun pulses");
      for (n = 0; n < 16; n++) pop_check(exp_q.pop_front());
      check_bit(rx_ready, 1'b0, "rx_ready_o after drain");

      // Flush
      send_random(1'b0);
      send_random(1'b0);
      wait_ready(ok);
      if (!ok) disable test_body;
      fifo_clear = 1'b1;
      @(negedge clk);
      fifo_clear = 1'b0;
      check_bit(rx_ready, 1'b0, "rx_ready_o after flush");
    end

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
             check_cnt, mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
logic/uart_rx_cfg_pkg.sv
logic/uart_rx_data_pkg.sv
logic/uart_rx_sampler.sv
logic/uart_rx_framer.sv
logic/uart_rx_fifo.sv
logic/uart_rx_top.sv
tests/uart_rx_assertions.sv
tests/uart_rx_tb.sv

// ==== Bender.yml ====
package:
  name: uart_rx

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_rx_cfg_pkg.sv
      - logic/uart_rx_data_pkg.sv
      - logic/uart_rx_sampler.sv
      - logic/uart_rx_framer.sv
      - logic/uart_rx_fifo.sv
      - logic/uart_rx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/uart_rx_assertions.sv
      - tests/uart_rx_tb.sv
